/* lsuPkg.sv */
`default_nettype none

package lsuPkg;

    localparam int SqnWidth = 6;
    localparam int MemWords = 64;
    localparam int MemIdxWidth = $clog2(MemWords);
    localparam int MemLatMin = 2;
    localparam int MemLatMax = 5;

    typedef enum logic [2:0] {
        none,
        readByte,
        readHalf,
        readWord,
        writeByte,
        writeHalf,
        writeWord
    } MemCmd;

    // valid sits in the MSB of both uop structs
    typedef struct packed {
        logic valid;
        logic external;                 // Non-speculative, never squashed
        logic [SqnWidth-1:0] sqN;
        logic [1:0] size;               // 0 byte, 1 half, 2 word
        logic [31:0] addr;
        logic [3:0] tag;
    } LdUop;

    typedef struct packed {
        logic valid;
        logic [3:0] wmask;
        logic [31:0] addr;
        logic [31:0] data;              // Already placed in its byte lanes
    } StUop;

    // Younger than a taken branch and not external
    function automatic logic squashes(input logic taken, input logic [SqnWidth-1:0] brSqN,
                                      input logic external, input logic [SqnWidth-1:0] sqN);
        return taken && !external && ($signed(sqN - brSqN) > 0);
    endfunction

endpackage

`default_nettype wire

/* uopBuffer.sv */
`default_nettype none

module uopBuffer #(
    parameter type PayloadT = lsuPkg::LdUop,
    parameter bit Squashable = 1'b0
) (
    input wire clk,
    input wire rst,
    input wire push,
    input wire PayloadT pushData,
    input wire pop,
    input wire branchTaken,
    input wire [lsuPkg::SqnWidth-1:0] branchSqN,
    output logic full,
    output PayloadT head
);

    localparam int ValidBit = $bits(PayloadT) - 1;

    PayloadT mem [4];
    logic [3:0] vld;
    logic [1:0] wrPtr;
    logic [1:0] rdPtr;
    logic [2:0] count;
    logic [3:0] squash;
    logic pushSquash;
    logic pushOk;
    logic advance;

    if (Squashable) begin : genSquash
        always_comb begin
            for (int i = 0; i < 4; i++) begin
                squash[i] = lsuPkg::squashes(branchTaken, branchSqN,
                                             mem[i].external, mem[i].sqN);
            end
            pushSquash = lsuPkg::squashes(branchTaken, branchSqN,
                                          pushData.external, pushData.sqN);
        end
    end else begin : genNoSquash
        assign squash = 4'b0000;
        assign pushSquash = 1'b0;
    end

    assign full = count == 3'd4;
    assign pushOk = push && !full;
    // Squashed heads are skipped without a pop
    assign advance = pop || (count != 3'd0 && !vld[rdPtr]);

    always_comb begin
        head = mem[rdPtr];
        head[ValidBit] = vld[rdPtr] && count != 3'd0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= 4'b0000;
            wrPtr <= 2'd0;
            rdPtr <= 2'd0;
            count <= 3'd0;
        end else begin
            vld <= vld & ~squash;
            if (pushOk) begin
                vld[wrPtr] <= pushData[ValidBit] && !pushSquash;
                wrPtr <= wrPtr + 2'd1;
            end
            if (advance) rdPtr <= rdPtr + 2'd1;
            count <= count + 3'(pushOk) - 3'(advance);
        end
    end

    always_ff @(posedge clk) begin
        if (pushOk) mem[wrPtr] <= pushData;
    end

endmodule

`default_nettype wire

/* bypassLsu.sv */
`default_nettype none

module bypassLsu (
    input wire clk,
    input wire rst,
    input wire branchTaken,
    input wire [lsuPkg::SqnWidth-1:0] branchSqN,
    input wire lsuPkg::LdUop ldHead,
    input wire lsuPkg::StUop stHead,
    input wire memStall,
    input wire rdValid,
    input wire [31:0] rdData,
    input wire wrDone,
    input wire ldStall,
    output logic ldPop,
    output logic stPop,
    output lsuPkg::MemCmd memCmd,
    output logic [31:0] memAddr,
    output logic [31:0] memWrData,
    output lsuPkg::LdUop ldOut,
    output logic [31:0] ldData
);

    typedef enum logic [2:0] {
        idle,
        reqLd,
        reqSt,
        waitLd,
        waitSt,
        doneLd
    } StateT;

    StateT state;
    lsuPkg::LdUop activeLd;
    lsuPkg::MemCmd stCmd;
    lsuPkg::MemCmd ldCmd;
    logic [1:0] stLow;
    logic headKill;
    logic activeKill;

    // Stores win over loads in the same cycle
    assign stPop = state == idle && stHead.valid;
    assign ldPop = state == idle && !stHead.valid && ldHead.valid;

    assign headKill = lsuPkg::squashes(branchTaken, branchSqN, ldHead.external, ldHead.sqN);
    // No squash once the result is on ldOut
    assign activeKill = (state == reqLd || state == waitLd) &&
        lsuPkg::squashes(branchTaken, branchSqN, activeLd.external, activeLd.sqN);

    always_comb begin
        case (stHead.wmask)
            4'b0001: begin stCmd = lsuPkg::writeByte; stLow = 2'd0; end
            4'b0010: begin stCmd = lsuPkg::writeByte; stLow = 2'd1; end
            4'b0100: begin stCmd = lsuPkg::writeByte; stLow = 2'd2; end
            4'b1000: begin stCmd = lsuPkg::writeByte; stLow = 2'd3; end
            4'b0011: begin stCmd = lsuPkg::writeHalf; stLow = 2'd0; end
            4'b1100: begin stCmd = lsuPkg::writeHalf; stLow = 2'd2; end
            default: begin stCmd = lsuPkg::writeWord; stLow = 2'd0; end
        endcase
    end

    always_comb begin
        case (ldHead.size)
            2'd0: ldCmd = lsuPkg::readByte;
            2'd1: ldCmd = lsuPkg::readHalf;
            default: ldCmd = lsuPkg::readWord;
        endcase
    end

    always_comb begin
        ldOut = activeLd;
        ldOut.valid = state == doneLd;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            memCmd <= lsuPkg::none;
            activeLd.valid <= 1'b0;
        end else begin
            if (activeKill) activeLd.valid <= 1'b0;
            case (state)
                idle: begin
                    if (stPop) begin
                        memCmd <= stCmd;
                        memAddr <= {stHead.addr[31:2], stLow};
                        memWrData <= stHead.data;
                        state <= reqSt;
                    end else if (ldPop && !headKill) begin   // Squashed head is popped and dropped
                        memCmd <= ldCmd;
                        memAddr <= ldHead.addr;
                        activeLd <= ldHead;
                        state <= reqLd;
                    end
                end
                reqLd, reqSt: begin
                    if (!memStall) begin
                        memCmd <= lsuPkg::none;
                        state <= (state == reqLd) ? waitLd : waitSt;
                    end
                end
                waitLd: begin
                    if (rdValid) begin
                        case (activeLd.size)
                            2'd0: ldData <= {4{rdData[7:0]}};
                            2'd1: ldData <= {2{rdData[15:0]}};
                            default: ldData <= rdData;
                        endcase
                        // A squashed load still drains its response
                        state <= (activeLd.valid && !activeKill) ? doneLd : idle;
                    end
                end
                waitSt: begin
                    if (wrDone) state <= idle;
                end
                doneLd: begin
                    if (!ldStall) begin
                        state <= idle;
                        activeLd.valid <= 1'b0;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* uncachedMemCtrl.sv */
`default_nettype none

module uncachedMemCtrl (
    input wire clk,
    input wire rst,
    input wire lsuPkg::MemCmd memCmd,
    input wire [31:0] memAddr,
    input wire [31:0] memWrData,
    output logic memStall,
    output logic rdValid,
    output logic [31:0] rdData,
    output logic wrDone
);

    logic [31:0] mem [lsuPkg::MemWords];
    logic [7:0] lfsr;
    logic busy;
    logic [2:0] latCnt;
    lsuPkg::MemCmd reqCmd;
    logic [lsuPkg::MemIdxWidth-1:0] reqIdx;
    logic [1:0] reqLow;
    logic [31:0] reqData;
    logic clearing;
    logic clrDone;
    logic [lsuPkg::MemIdxWidth-1:0] clrIdx;
    logic accept;
    logic fire;
    logic [3:0] wrMask;
    logic [31:0] rdWord;

    assign memStall = busy || clearing;
    assign accept = memCmd != lsuPkg::none && !memStall;
    assign fire = busy && latCnt == 3'd0;
    assign rdWord = mem[reqIdx] >> {reqLow, 3'b000};   // Right-align the addressed lane

    always_comb begin
        case (reqCmd)
            lsuPkg::writeByte: wrMask = 4'b0001 << reqLow;
            lsuPkg::writeHalf: wrMask = 4'b0011 << reqLow;
            lsuPkg::writeWord: wrMask = 4'b1111;
            default: wrMask = 4'b0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= 8'hA5;
            busy <= 1'b0;
            latCnt <= 3'd0;
            reqCmd <= lsuPkg::none;
            rdValid <= 1'b0;
            wrDone <= 1'b0;
            clearing <= 1'b0;
            clrDone <= 1'b0;
            clrIdx <= '0;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            rdValid <= 1'b0;
            wrDone <= 1'b0;
            if (!clrDone) begin
                clearing <= 1'b1;
                if (clearing) begin
                    clrIdx <= clrIdx + 1'b1;
                    if (clrIdx == lsuPkg::MemIdxWidth'(lsuPkg::MemWords - 1)) begin
                        clearing <= 1'b0;
                        clrDone <= 1'b1;
                    end
                end
            end
            if (accept) begin
                busy <= 1'b1;
                reqCmd <= memCmd;
                // Counts down to the response, total latency MemLatMin..MemLatMax
                latCnt <= 3'(int'(lfsr) % (lsuPkg::MemLatMax - lsuPkg::MemLatMin + 1) +
                              lsuPkg::MemLatMin - 2);
            end else if (busy) begin
                if (latCnt == 3'd0) begin
                    busy <= 1'b0;
                    wrDone <= wrMask != 4'b0000;
                    rdValid <= wrMask == 4'b0000;
                end else begin
                    latCnt <= latCnt - 3'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            reqIdx <= memAddr[2 +: lsuPkg::MemIdxWidth];
            reqLow <= memAddr[1:0];
            reqData <= memWrData;
        end
        if (fire) begin
            case (reqCmd)
                lsuPkg::readByte: rdData <= {24'b0, rdWord[7:0]};
                lsuPkg::readHalf: rdData <= {16'b0, rdWord[15:0]};
                default: rdData <= mem[reqIdx];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (clearing) begin
            mem[clrIdx] <= 32'b0;
        end else if (fire) begin
            for (int b = 0; b < 4; b++) begin
                if (wrMask[b]) mem[reqIdx][8*b +: 8] <= reqData[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

/* lsuTop.sv */
`default_nettype none

module lsuTop (
    input wire clk,
    input wire rst,
    input wire ldPush,
    input wire lsuPkg::LdUop ldIn,
    output logic ldFull,
    input wire stPush,
    input wire lsuPkg::StUop stIn,
    output logic stFull,
    input wire branchTaken,
    input wire [lsuPkg::SqnWidth-1:0] branchSqN,
    output lsuPkg::LdUop ldOut,
    output logic [31:0] ldData,
    input wire ldStall
);

    wire lsuPkg::LdUop ldHead;
    wire lsuPkg::StUop stHead;
    wire ldPop;
    wire stPop;
    wire lsuPkg::MemCmd memCmd;
    wire [31:0] memAddr;
    wire [31:0] memWrData;
    wire memStall;
    wire rdValid;
    wire [31:0] rdData;
    wire wrDone;

    uopBuffer #(
        .PayloadT(lsuPkg::LdUop),
        .Squashable(1'b1)
    ) u_ldBuf (
        .clk(clk),
        .rst(rst),
        .push(ldPush),
        .pushData(ldIn),
        .pop(ldPop),
        .branchTaken(branchTaken),
        .branchSqN(branchSqN),
        .full(ldFull),
        .head(ldHead)
    );

    uopBuffer #(
        .PayloadT(lsuPkg::StUop),
        .Squashable(1'b0)
    ) u_stBuf (
        .clk(clk),
        .rst(rst),
        .push(stPush),
        .pushData(stIn),
        .pop(stPop),
        .branchTaken(branchTaken),
        .branchSqN(branchSqN),
        .full(stFull),
        .head(stHead)
    );

    bypassLsu u_lsu (
        .clk(clk),
        .rst(rst),
        .branchTaken(branchTaken),
        .branchSqN(branchSqN),
        .ldHead(ldHead),
        .stHead(stHead),
        .memStall(memStall),
        .rdValid(rdValid),
        .rdData(rdData),
        .wrDone(wrDone),
        .ldStall(ldStall),
        .ldPop(ldPop),
        .stPop(stPop),
        .memCmd(memCmd),
        .memAddr(memAddr),
        .memWrData(memWrData),
        .ldOut(ldOut),
        .ldData(ldData)
    );

    uncachedMemCtrl u_memCtrl (
        .clk(clk),
        .rst(rst),
        .memCmd(memCmd),
        .memAddr(memAddr),
        .memWrData(memWrData),
        .memStall(memStall),
        .rdValid(rdValid),
        .rdData(rdData),
        .wrDone(wrDone)
    );

endmodule

`default_nettype wire

/* tbClockGen.sv */
`default_nettype none

module tbClockGen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

    always #2 clk = ~clk;   // Period of 4

endmodule

`default_nettype wire

/* tbLsu.sv */
`default_nettype none

module tbLsu;

    localparam int NumStLd = 24;
    localparam int MergeWords = 4;
    localparam int SquashLoads = 40;
    localparam int StallLoads = 24;
    localparam int MixedOps = 32;
    localparam int NumOps = 2 * NumStLd + 4 * MergeWords + SquashLoads + StallLoads + MixedOps;
    localparam int CycleLimit = 40 * NumOps + lsuPkg::MemWords + 16;
    localparam int StallPatLen = 256;

    typedef struct {
        logic [3:0] tag;
        logic [lsuPkg::SqnWidth-1:0] sqN;
        logic external;
        logic [31:0] data;
    } ExpT;

    wire clk;
    wire rst;
    logic ldPush;
    lsuPkg::LdUop ldIn;
    wire ldFull;
    logic stPush;
    lsuPkg::StUop stIn;
    wire stFull;
    logic branchTaken;
    logic [lsuPkg::SqnWidth-1:0] branchSqN;
    wire lsuPkg::LdUop ldOut;
    wire [31:0] ldData;
    logic ldStall = 1'b0;

    logic [31:0] shadow [lsuPkg::MemWords];    // Reference copy of the controller memory
    ExpT expQ[$];                              // Expected load results in push order
    logic stallPat [StallPatLen];
    int stallPos = 0;
    logic stallMode = 1'b0;
    logic pushDone;
    logic anyPush = 1'b0;
    logic [3:0] nextTag = 4'd0;
    logic [lsuPkg::SqnWidth-1:0] nextSqn = '0;
    string testName = "reset";
    int errors = 0;
    int checks = 0;
    int squashed = 0;
    int cycles = 0;
    lsuPkg::LdUop prevOut;
    logic [31:0] prevData;
    logic prevHeld = 1'b0;

    tbClockGen u_clkGen (.clk(clk), .rst(rst));

    lsuTop u_lsuTop (
        .clk(clk),
        .rst(rst),
        .ldPush(ldPush),
        .ldIn(ldIn),
        .ldFull(ldFull),
        .stPush(stPush),
        .stIn(stIn),
        .stFull(stFull),
        .branchTaken(branchTaken),
        .branchSqN(branchSqN),
        .ldOut(ldOut),
        .ldData(ldData),
        .ldStall(ldStall)
    );

    function automatic logic isYounger(input logic [lsuPkg::SqnWidth-1:0] sqN,
                                       input logic [lsuPkg::SqnWidth-1:0] brSqN);
        logic [lsuPkg::SqnWidth-1:0] diff;
        diff = sqN - brSqN;
        return !diff[lsuPkg::SqnWidth-1] && diff != '0;
    endfunction

    function automatic logic [31:0] expectedLoad(input logic [31:0] word, input logic [1:0] off,
                                                 input logic [1:0] size);
        logic [31:0] sh;
        sh = word >> {off, 3'b000};
        case (size)
            2'd0: return {4{sh[7:0]}};
            2'd1: return {2{sh[15:0]}};
            default: return word;
        endcase
    endfunction

    function automatic logic [31:0] mergeStore(input logic [31:0] old, input logic [3:0] mask,
                                               input logic [31:0] data);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    function automatic logic [3:0] legalMask(input logic allowWord);
        case ($urandom_range(allowWord ? 6 : 5))
            0: return 4'b0001;
            1: return 4'b0010;
            2: return 4'b0100;
            3: return 4'b1000;
            4: return 4'b0011;
            5: return 4'b1100;
            default: return 4'b1111;
        endcase
    endfunction

    task automatic fillStallPattern();
        int pos;
        int len;
        logic level;
        pos = 0;
        level = 1'b0;
        while (pos < StallPatLen) begin
            len = $urandom_range(1, 8);
            level = !level;
            for (int k = 0; k < len && pos < StallPatLen; k++) begin
                stallPat[pos] = level;
                pos++;
            end
        end
    endtask

    task automatic pushStore(input int word, input logic [3:0] mask, input logic [31:0] data);
        @(negedge clk);
        while (stFull) @(negedge clk);
        @(posedge clk);
        stPush <= 1'b1;
        stIn.valid <= 1'b1;
        stIn.wmask <= mask;
        stIn.addr <= {30'(word), 2'b00};
        stIn.data <= data;
        shadow[word] = mergeStore(shadow[word], mask, data);
        anyPush = 1'b1;
        @(posedge clk);
        stPush <= 1'b0;
    endtask

    task automatic pushLoad(input int word, input logic [1:0] size, input logic ext);
        logic [1:0] off;
        ExpT e;
        case (size)
            2'd0: off = 2'($urandom_range(3));
            2'd1: off = {1'($urandom_range(1)), 1'b0};
            default: off = 2'd0;
        endcase
        @(negedge clk);
        while (ldFull) @(negedge clk);
        @(posedge clk);
        ldPush <= 1'b1;
        ldIn.valid <= 1'b1;
        ldIn.external <= ext;
        ldIn.sqN <= nextSqn;
        ldIn.size <= size;
        ldIn.addr <= {30'(word), off};
        ldIn.tag <= nextTag;
        e.tag = nextTag;
        e.sqN = nextSqn;
        e.external = ext;
        e.data = expectedLoad(shadow[word], off, size);
        expQ.push_back(e);
        nextTag = nextTag + 4'd1;
        nextSqn = nextSqn + 1'b1;
        anyPush = 1'b1;
        @(posedge clk);
        ldPush <= 1'b0;
    endtask

    // Random draws happen on the falling edge, the load pusher draws on the rising edge
    task automatic driveBranches();
        int gap;
        logic [lsuPkg::SqnWidth-1:0] back;
        logic [lsuPkg::SqnWidth-1:0] brSqN;
        while (!pushDone) begin
            @(negedge clk);
            gap = $urandom_range(3, 12);
            back = lsuPkg::SqnWidth'($urandom_range(1, 6));
            repeat (gap) @(negedge clk);
            brSqN = nextSqn - back;
            @(posedge clk);
            branchTaken <= 1'b1;
            branchSqN <= brSqN;
            @(posedge clk);
            branchTaken <= 1'b0;
        end
    endtask

    always @(posedge clk) begin
        if (stallMode) begin
            ldStall <= stallPat[stallPos];
            stallPos <= (stallPos + 1) % StallPatLen;
        end else begin
            ldStall <= 1'b0;
        end
    end

    always @(negedge clk) begin : monitor
        ExpT keep[$];
        ExpT e;
        if (!rst) begin
            if (!anyPush) begin
                assert (!ldOut.valid && !ldFull && !stFull) else begin
                    errors++;
                    $display("outputs active after reset before the first push");
                end
            end
            if (prevHeld) begin
                assert (ldOut == prevOut && ldData == prevData) else begin
                    errors++;
                    $display("mismatch %s: expected %h %h actual %h %h", testName,
                             prevOut, prevData, ldOut, ldData);
                end
            end
            if (ldOut.valid && !ldStall) begin
                checks++;
                assert (expQ.size() > 0) else begin
                    errors++;
                    $display("load result with tag %0d arrived with no load outstanding",
                             ldOut.tag);
                end
                if (expQ.size() > 0) begin
                    e = expQ.pop_front();
                    assert (ldOut.tag == e.tag) else begin
                        errors++;
                        $display("mismatch %s: expected tag %h actual %h", testName,
                                 e.tag, ldOut.tag);
                    end
                    assert (ldData == e.data) else begin
                        errors++;
                        $display("mismatch %s: expected %h actual %h", testName,
                                 e.data, ldData);
                    end
                end
            end
            if (branchTaken) begin
                keep.delete();
                for (int i = 0; i < expQ.size(); i++) begin
                    // A result already on ldOut survives
                    if ((i == 0 && ldOut.valid && ldStall) || expQ[i].external ||
                        !isYounger(expQ[i].sqN, branchSqN)) begin
                        keep.push_back(expQ[i]);
                    end else begin
                        squashed++;
                    end
                end
                expQ = keep;
            end
            prevHeld = ldOut.valid && ldStall;
            prevOut = ldOut;
            prevData = ldData;
        end
    end

    always @(negedge clk) begin
        cycles++;
        if (cycles > CycleLimit) begin
            $display("timeout after %0d cycles in %s with %0d results outstanding",
                     cycles, testName, expQ.size());
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h5438));
        ldPush <= 1'b0;
        ldIn <= '0;
        stPush <= 1'b0;
        stIn <= '0;
        branchTaken <= 1'b0;
        branchSqN <= '0;
        for (int w = 0; w < lsuPkg::MemWords; w++) shadow[w] = 32'h0;
        fillStallPattern();
        @(negedge clk);
        while (rst) @(negedge clk);
        repeat (4) @(negedge clk);

        testName = "storeThenLoad";
        for (int i = 0; i < NumStLd; i++) begin
            pushStore($urandom_range(0, 15), legalMask(1'b1), $urandom);
        end
        for (int i = 0; i < NumStLd; i++) begin
            pushLoad($urandom_range(0, 15), 2'($urandom_range(2)), 1'b0);
        end

        testName = "subWordMerge";
        for (int w = 16; w < 16 + MergeWords; w++) begin
            pushStore(w, legalMask(1'b0), $urandom);
            pushStore(w, legalMask(1'b0), $urandom);
            pushStore(w, legalMask(1'b0), $urandom);
            pushLoad(w, 2'd2, 1'b0);
        end

        testName = "branchSquash";
        pushDone = 1'b0;
        fork
            begin
                for (int i = 0; i < SquashLoads; i++) begin
                    pushLoad($urandom_range(0, 19), 2'($urandom_range(2)),
                             $urandom_range(3) == 0);
                end
                pushDone = 1'b1;
            end
            driveBranches();
        join

        testName = "backPressure";
        @(negedge clk);
        stallMode = 1'b1;
        for (int i = 0; i < StallLoads; i++) begin
            pushLoad($urandom_range(0, 19), 2'($urandom_range(2)), 1'b0);
        end
        while (expQ.size() > 0) @(negedge clk);
        stallMode = 1'b0;

        testName = "mixedTraffic";   // Stores to words 32..47, loads from words 0..19
        for (int i = 0; i < MixedOps; i++) begin
            if ($urandom_range(1) == 0) begin
                pushStore(32 + $urandom_range(0, 15), legalMask(1'b1), $urandom);
            end else begin
                pushLoad($urandom_range(0, 19), 2'($urandom_range(2)), 1'b0);
            end
        end
        while (expQ.size() > 0) @(negedge clk);
        repeat (20) @(negedge clk);   // Catch late or duplicated results

        $display("results checked %0d, loads squashed %0d, errors %0d", checks, squashed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
lsuPkg.sv
uopBuffer.sv
bypassLsu.sv
uncachedMemCtrl.sv
lsuTop.sv
tbClockGen.sv
tbLsu.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f flist.f --top-module tbLsu -o simLsu
	./obj_dir/simLsu | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
